/* source/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    parameter int XLEN = 32;

    // Major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011  // Not supported, decodes as illegal
    } opcode_e;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_FENCE,   // FENCE and FENCE.I
        CLS_ILLEGAL
    } instr_class_e;

    typedef logic [4:0] reg_idx_t;

    // R-type layout, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_fields_t;

endpackage

`default_nettype wire

/* source/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        logic     enable;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } rd_rf_uop_t;

    typedef struct packed {
        logic       enable;
        logic       is_branch;
        logic       alt;     // SUB, SRA or SRAI
        logic [2:0] funct3;
    } ex_alu_uop_t;

    typedef struct packed {
        logic       enable;
        logic       is_store;
        logic [2:0] funct3;  // Access size and sign
    } ma_mem_uop_t;

    typedef struct packed {
        logic     enable;
        reg_idx_t rd;
    } wb_rf_uop_t;

    typedef enum logic {
        ALU_A_RS1,
        ALU_A_PC
    } alu_a_sel_e;

    typedef enum logic {
        ALU_B_RS2,
        ALU_B_IMM
    } alu_b_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_IMM,
        WB_MEM,
        WB_NPC
    } wb_sel_e;

    typedef enum logic [1:0] {
        PC_NPC,
        PC_JALR_TARGET,
        PC_OFFSET,
        PC_BRANCH  // Taken ? pc + offset : npc
    } pc_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] imm;
        rd_rf_uop_t      rd_rf;
        ex_alu_uop_t     ex_alu;
        ma_mem_uop_t     ma_mem;
        wb_rf_uop_t      wb_rf;
        alu_a_sel_e      alu_a_sel;
        alu_b_sel_e      alu_b_sel;
        wb_sel_e         wb_sel;
        pc_sel_e         pc_sel;
    } decode_out_t;

endpackage

`default_nettype wire

/* source/opcode_classifier.sv */
`timescale 1ns/1ns
`default_nettype none

module opcode_classifier import rv_isa_pkg::*; (
    input  logic [31:0]   instr,
    output instr_fields_t fields,
    output instr_class_e  cls,
    output logic          bad_opcode
);

    assign fields = instr_fields_t'(instr);

    always_comb begin
        cls = CLS_ILLEGAL;
        // Compressed encodings are not accepted
        if (fields.opcode[1:0] == 2'b11) begin
            case (fields.opcode)
                OPC_LUI:      cls = CLS_LUI;
                OPC_AUIPC:    cls = CLS_AUIPC;
                OPC_JAL:      cls = CLS_JAL;
                OPC_JALR:     cls = CLS_JALR;
                OPC_BRANCH:   cls = CLS_BRANCH;
                OPC_LOAD:     cls = CLS_LOAD;
                OPC_STORE:    cls = CLS_STORE;
                OPC_OP_IMM:   cls = CLS_OP_IMM;
                OPC_OP:       cls = CLS_OP;
                OPC_MISC_MEM: cls = CLS_FENCE;
                default:      cls = CLS_ILLEGAL;  // SYSTEM lands here
            endcase
        end
    end

    assign bad_opcode = (cls == CLS_ILLEGAL);

endmodule

`default_nettype wire

/* source/field_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module field_checker import rv_isa_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  instr_fields_t fields,
    input  instr_class_e  cls,
    input  logic          bad_opcode,
    output logic          illegal
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic reads_rs1;
    logic reads_rs2;
    logic writes_rd;
    logic is_fence;
    logic is_fence_i;
    logic bad_rs;
    logic bad_rd;
    logic bad_funct3;
    logic bad_funct7;

    function automatic logic out_of_range(input reg_idx_t idx);
        return 32'(idx) >= NUM_REGS;
    endfunction

    assign reads_rs1  = cls inside {CLS_JALR, CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_OP};
    assign reads_rs2  = cls inside {CLS_BRANCH, CLS_STORE, CLS_OP};
    assign writes_rd  = cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_LOAD,
                                    CLS_OP_IMM, CLS_OP};
    assign is_fence   = (cls == CLS_FENCE);
    assign is_fence_i = is_fence & fields.funct3[0];

    // FENCE keeps pred/succ in rs2 and funct7[2:0], FENCE.I has none
    assign bad_rs = (reads_rs1 & out_of_range(fields.rs1))
                  | (reads_rs2 & out_of_range(fields.rs2))
                  | (is_fence & (fields.rs1 != '0))
                  | (is_fence_i & (fields.rs2 != '0));

    assign bad_rd = (writes_rd & out_of_range(fields.rd))
                  | (is_fence & (fields.rd != '0));

    always_comb begin
        case (cls)
            CLS_JALR:   bad_funct3 = (fields.funct3 != 3'b000);
            CLS_LOAD:   bad_funct3 = fields.funct3 inside {3'b011, 3'b110, 3'b111};
            CLS_STORE:  bad_funct3 = fields.funct3[2] | (fields.funct3 == 3'b011);
            CLS_BRANCH: bad_funct3 = (fields.funct3[2:1] == 2'b01);
            CLS_FENCE:  bad_funct3 = (fields.funct3[2:1] != 2'b00);
            default:    bad_funct3 = 1'b0;
        endcase
    end

    always_comb begin
        case (cls)
            CLS_OP: begin
                bad_funct7 = !((fields.funct7 == F7_BASE) ||
                               ((fields.funct7 == F7_ALT) &&
                                (fields.funct3 inside {3'b000, 3'b101})));
            end
            CLS_OP_IMM: begin
                if (fields.funct3 == 3'b001) begin
                    bad_funct7 = (fields.funct7 != F7_BASE);  // SLLI
                end else if (fields.funct3 == 3'b101) begin
                    bad_funct7 = !(fields.funct7 inside {F7_BASE, F7_ALT});  // SRLI/SRAI
                end else begin
                    bad_funct7 = 1'b0;  // Plain immediate
                end
            end
            CLS_FENCE: begin
                bad_funct7 = (fields.funct7[6:3] != 4'b0000)
                           | (is_fence_i & (fields.funct7[2:0] != 3'b000));
            end
            default: bad_funct7 = 1'b0;
        endcase
    end

    assign illegal = bad_opcode | bad_rs | bad_rd | bad_funct3 | bad_funct7;

endmodule

`default_nettype wire

/* source/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_gen import rv_isa_pkg::*; (
    input  instr_fields_t fields,
    input  instr_class_e  cls,
    output logic [31:0]   imm
);

    logic        sign;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic [31:0] imm_s;
    logic [31:0] imm_i;

    assign sign = fields.funct7[6];  // Instruction bit 31

    assign imm_u = {fields.funct7, fields.rs2, fields.rs1, fields.funct3, 12'b0};

    assign imm_j = {{12{sign}}, fields.rs1, fields.funct3, fields.rs2[0],
                    fields.funct7[5:0], fields.rs2[4:1], 1'b0};

    assign imm_b = {{20{sign}}, fields.rd[0], fields.funct7[5:0], fields.rd[4:1], 1'b0};

    assign imm_s = {{20{sign}}, fields.funct7, fields.rd};

    assign imm_i = {{20{sign}}, fields.funct7, fields.rs2};

    always_comb begin
        case (cls)
            CLS_LUI,
            CLS_AUIPC:  imm = imm_u;
            CLS_JAL:    imm = imm_j;
            CLS_BRANCH: imm = imm_b;
            CLS_STORE:  imm = imm_s;
            default:    imm = imm_i;  // FENCE and OP get it too, unused there
        endcase
    end

endmodule

`default_nettype wire

/* source/microcode_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module microcode_gen import rv_isa_pkg::*, decode_pkg::*; (
    input  instr_fields_t fields,
    input  instr_class_e  cls,
    input  logic          illegal,
    input  logic [31:0]   imm,
    output decode_out_t   next_uops
);

    logic reads_rf;
    logic uses_alu;
    logic alu_funct;
    logic writes_rf;
    logic alt;

    assign reads_rf  = cls inside {CLS_JALR, CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_OP};
    assign uses_alu  = cls inside {CLS_OP, CLS_OP_IMM, CLS_BRANCH, CLS_LOAD, CLS_STORE,
                                   CLS_AUIPC, CLS_JALR};
    assign alu_funct = cls inside {CLS_OP, CLS_OP_IMM, CLS_BRANCH};
    assign writes_rf = cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_LOAD,
                                   CLS_OP_IMM, CLS_OP};

    // SUB and SRA on OP, SRAI on OP-IMM
    assign alt = fields.funct7[5] &
                 (((cls == CLS_OP) && (fields.funct3 inside {3'b000, 3'b101})) ||
                  ((cls == CLS_OP_IMM) && (fields.funct3 == 3'b101)));

    always_comb begin
        next_uops = '0;
        next_uops.imm = imm;

        next_uops.rd_rf.enable = ~illegal & reads_rf;
        next_uops.rd_rf.rs1    = fields.rs1;
        next_uops.rd_rf.rs2    = fields.rs2;

        next_uops.ex_alu.enable    = ~illegal & uses_alu;
        next_uops.ex_alu.is_branch = (cls == CLS_BRANCH);
        next_uops.ex_alu.alt       = alt;
        next_uops.ex_alu.funct3    = alu_funct ? fields.funct3 : 3'b000;  // Else plain add

        next_uops.ma_mem.enable   = ~illegal & (cls inside {CLS_LOAD, CLS_STORE});
        next_uops.ma_mem.is_store = (cls == CLS_STORE);
        next_uops.ma_mem.funct3   = fields.funct3;

        next_uops.wb_rf.enable = ~illegal & writes_rf;
        next_uops.wb_rf.rd     = fields.rd;

        next_uops.alu_a_sel = (cls == CLS_AUIPC) ? ALU_A_PC : ALU_A_RS1;
        next_uops.alu_b_sel = (cls inside {CLS_OP, CLS_BRANCH}) ? ALU_B_RS2 : ALU_B_IMM;

        case (cls)
            CLS_LOAD:         next_uops.wb_sel = WB_MEM;
            CLS_LUI:          next_uops.wb_sel = WB_IMM;
            CLS_JAL, CLS_JALR: next_uops.wb_sel = WB_NPC;  // Link address
            default:          next_uops.wb_sel = WB_ALU;
        endcase

        case (cls)
            CLS_JAL:    next_uops.pc_sel = PC_OFFSET;
            CLS_JALR:   next_uops.pc_sel = PC_JALR_TARGET;
            CLS_BRANCH: next_uops.pc_sel = PC_BRANCH;
            default:    next_uops.pc_sel = PC_NPC;
        endcase
    end

endmodule

`default_nettype wire

/* source/decode_control.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_control import decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        available,
    input  decode_out_t next_uops,
    input  logic        illegal,
    output decode_out_t uops,
    output logic        busy,
    output logic        fault
);

    logic started;
    logic capture;

    // Second cycle of a request, decode inputs have settled
    assign capture = busy & started;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
            busy    <= 1'b0;
        end else begin
            started <= available;
            busy    <= available & ~started;  // One pulse per rising request
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (capture) begin
            fault <= illegal;  // Sticky until the next request
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uops <= '0;
        end else if (capture) begin
            uops <= next_uops;
        end
    end

endmodule

`default_nettype wire

/* source/instruction_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instruction_decoder import rv_isa_pkg::*, decode_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        available,
    input  logic [31:0] instr,
    output decode_out_t uops,
    output logic        busy,
    output logic        fault
);

    instr_fields_t fields;
    instr_class_e  cls;
    logic          bad_opcode;
    logic          illegal;
    logic [31:0]   imm;
    decode_out_t   next_uops;

    opcode_classifier u_classifier (
        .instr      (instr),
        .fields     (fields),
        .cls        (cls),
        .bad_opcode (bad_opcode)
    );

    field_checker #(
        .NUM_REGS (NUM_REGS)
    ) u_checker (
        .fields     (fields),
        .cls        (cls),
        .bad_opcode (bad_opcode),
        .illegal    (illegal)
    );

    imm_gen u_imm (
        .fields (fields),
        .cls    (cls),
        .imm    (imm)
    );

    microcode_gen u_microcode (
        .fields    (fields),
        .cls       (cls),
        .illegal   (illegal),
        .imm       (imm),
        .next_uops (next_uops)
    );

    decode_control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .available (available),
        .next_uops (next_uops),
        .illegal   (illegal),
        .uops      (uops),
        .busy      (busy),
        .fault     (fault)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Release away from the active edge
    end

endmodule

`default_nettype wire

/* test/decoder_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module decoder_properties import decode_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        busy,
    input logic        fault,
    input decode_out_t uops
);

    int   failures = 0;
    logic any_enable;

    assign any_enable = uops.rd_rf.enable | uops.ex_alu.enable
                      | uops.ma_mem.enable | uops.wb_rf.enable;

    busy_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) busy |=> !busy)
        else begin
            $error("busy stayed high for more than one cycle");
            failures++;
        end

    // First edge out of reset sees the reset values
    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !fault)
        else begin
            $error("busy or fault set in the cycle after reset");
            failures++;
        end

    no_enable_on_fault: assert property (@(posedge clk) disable iff (!rst_n)
                                         fault |-> !any_enable)
        else begin
            $error("stage enable set while fault is high");
            failures++;
        end

endmodule

`default_nettype wire

/* test/instruction_decoder_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module instruction_decoder_tb import rv_isa_pkg::*, decode_pkg::*; ;

    localparam int NUM_REGS           = 16;
    localparam int RESET_CYCLES       = 5;
    localparam int DIRECTED_REQUESTS  = 45;
    localparam int RANDOM_WORDS       = 100;
    localparam int CYCLES_PER_REQUEST = 4;  // Upper bound, nominal is 3
    localparam int IDLE_CYCLES        = 20;
    localparam int WATCHDOG_CYCLES    = 2 * (RESET_CYCLES + IDLE_CYCLES +
                                        (DIRECTED_REQUESTS + RANDOM_WORDS) * CYCLES_PER_REQUEST);
    localparam logic [31:0] SEED = 32'h8b5c_af2b;
    localparam logic [6:0] KEPT_OPCODES [10] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM};

    logic        clk;
    logic        rst_n;
    logic        available;
    logic [31:0] instr;
    decode_out_t uops;
    logic        busy;
    logic        fault;
    int          errors;
    int          checks;

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clock (.clk(clk), .rst_n(rst_n));

    instruction_decoder #(.NUM_REGS(NUM_REGS)) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .available (available),
        .instr     (instr),
        .uops      (uops),
        .busy      (busy),
        .fault     (fault)
    );

    bind instruction_decoder decoder_properties u_properties (
        .clk(clk), .rst_n(rst_n), .busy(busy), .fault(fault), .uops(uops));

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // Reference decode straight from the ISA bit positions, returns the expected fault
    function automatic logic expected_decode(input logic [31:0] w, output decode_out_t want);
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       bad;
        logic       use_rs1;
        logic       use_rs2;
        logic       use_rd;
        opc = w[6:0];
        rd  = w[11:7];
        f3  = w[14:12];
        rs1 = w[19:15];
        rs2 = w[24:20];
        f7  = w[31:25];
        bad = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        want = '0;
        want.imm = {{20{w[31]}}, w[31:20]};
        want.rd_rf.rs1 = rs1;
        want.rd_rf.rs2 = rs2;
        want.wb_rf.rd = rd;
        want.ma_mem.funct3 = f3;
        want.alu_b_sel = ALU_B_IMM;
        case (opc)
            OPC_LUI: begin
                use_rd = 1'b1;
                want.imm = {w[31:12], 12'b0};
                want.wb_sel = WB_IMM;
            end
            OPC_AUIPC: begin
                use_rd = 1'b1;
                want.imm = {w[31:12], 12'b0};
                want.ex_alu.enable = 1'b1;
                want.alu_a_sel = ALU_A_PC;
            end
            OPC_JAL: begin
                use_rd = 1'b1;
                want.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                want.wb_sel = WB_NPC;
                want.pc_sel = PC_OFFSET;
            end
            OPC_JALR: begin
                use_rd = 1'b1;
                use_rs1 = 1'b1;
                want.ex_alu.enable = 1'b1;
                want.wb_sel = WB_NPC;
                want.pc_sel = PC_JALR_TARGET;
                bad = (f3 != 3'd0);
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                want.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                want.ex_alu = '{enable: 1'b1, is_branch: 1'b1, alt: 1'b0, funct3: f3};
                want.alu_b_sel = ALU_B_RS2;
                want.pc_sel = PC_BRANCH;
                bad = f3 inside {3'd2, 3'd3};
            end
            OPC_LOAD: begin
                use_rd = 1'b1;
                use_rs1 = 1'b1;
                want.ex_alu.enable = 1'b1;
                want.ma_mem.enable = 1'b1;
                want.wb_sel = WB_MEM;
                bad = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            end
            OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                want.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                want.ex_alu.enable = 1'b1;
                want.ma_mem.enable = 1'b1;
                want.ma_mem.is_store = 1'b1;
                bad = (f3 > 3'd2);
            end
            OPC_OP_IMM: begin
                use_rd = 1'b1;
                use_rs1 = 1'b1;
                want.ex_alu = '{enable: 1'b1, is_branch: 1'b0, alt: w[30] && (f3 == 3'd5),
                                funct3: f3};
                if (f3 == 3'd1) begin
                    bad = (f7 != 7'h00);
                end else if (f3 == 3'd5) begin
                    bad = !(f7 inside {7'h00, 7'h20});
                end
            end
            OPC_OP: begin
                use_rd = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                want.ex_alu = '{enable: 1'b1, is_branch: 1'b0,
                                alt: w[30] && (f3 inside {3'd0, 3'd5}), funct3: f3};
                want.alu_b_sel = ALU_B_RS2;
                bad = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 inside {3'd0, 3'd5})));
            end
            OPC_MISC_MEM: begin
                // FENCE.I keeps no pred/succ bits
                bad = (rd != 5'd0) || (rs1 != 5'd0) || (f3 > 3'd1) || (w[31:28] != 4'd0)
                    || (f3[0] && (w[27:20] != 8'd0));
            end
            default: bad = 1'b1;
        endcase
        bad = bad || (use_rs1 && (32'(rs1) >= NUM_REGS)) || (use_rs2 && (32'(rs2) >= NUM_REGS))
                  || (use_rd && (32'(rd) >= NUM_REGS));
        want.rd_rf.enable  = use_rs1 & ~bad;
        want.wb_rf.enable  = use_rd & ~bad;
        want.ex_alu.enable = want.ex_alu.enable & ~bad;
        want.ma_mem.enable = want.ma_mem.enable & ~bad;
        return bad;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Fail %s: got %h, expected %h, instr %h", name, got, want, instr);
        end
    endtask

    task automatic compare_outputs(input decode_out_t want, input logic want_fault);
        check_equal("fault", fault, want_fault);
        check_equal("uops.imm", uops.imm, want.imm);
        check_equal("uops.rd_rf", uops.rd_rf, want.rd_rf);
        check_equal("uops.ex_alu", uops.ex_alu, want.ex_alu);
        check_equal("uops.ma_mem", uops.ma_mem, want.ma_mem);
        check_equal("uops.wb_rf", uops.wb_rf, want.wb_rf);
        check_equal("uops.alu_a_sel", uops.alu_a_sel, want.alu_a_sel);
        check_equal("uops.alu_b_sel", uops.alu_b_sel, want.alu_b_sel);
        check_equal("uops.wb_sel", uops.wb_sel, want.wb_sel);
        check_equal("uops.pc_sel", uops.pc_sel, want.pc_sel);
    endtask

    task automatic check_no_enables();
        check_equal("uops enables", {uops.rd_rf.enable, uops.ex_alu.enable,
                                     uops.ma_mem.enable, uops.wb_rf.enable}, 32'h0);
    endtask

    // Called on a falling edge, returns on a falling edge with available low
    task automatic run_request(input logic [31:0] word);
        decode_out_t want;
        logic        want_fault;
        instr = word;
        available = 1'b1;
        @(negedge clk);
        while (busy !== 1'b1) @(negedge clk);
        while (busy !== 1'b0) @(negedge clk);
        want_fault = expected_decode(word, want);
        compare_outputs(want, want_fault);
        available = 1'b0;
        @(negedge clk);
    endtask

    task automatic test_reset_and_handshake();
        decode_out_t want;
        logic        want_fault;
        check_equal("busy", busy, 1'b0);
        check_equal("fault", fault, 1'b0);
        check_no_enables();
        instr = encode(7'h7f, 5'h1f, 5'd6, 3'd0, 5'd5, OPC_OP_IMM);  // addi x5, x6, -1
        want_fault = expected_decode(instr, want);
        available = 1'b1;
        @(negedge clk);
        check_equal("busy", busy, 1'b1);
        check_equal("uops.wb_rf", uops.wb_rf, 32'h0);  // Not yet captured
        @(negedge clk);
        check_equal("busy", busy, 1'b0);
        compare_outputs(want, want_fault);
        @(negedge clk);
        check_equal("busy", busy, 1'b0);  // Level held, no second pulse
        available = 1'b0;
        @(negedge clk);
    endtask

    task automatic test_immediates();
        run_request(encode(7'h40, 5'h00, 5'h00, 3'd1, 5'd1, OPC_LUI));
        run_request(encode(7'h12, 5'h13, 5'h04, 3'd5, 5'd2, OPC_LUI));
        run_request(encode(7'h7e, 5'h0a, 5'h1f, 3'd3, 5'd3, OPC_AUIPC));
        run_request(encode(7'h55, 5'h0b, 5'h1e, 3'd6, 5'd1, OPC_JAL));
        run_request(encode(7'h2a, 5'h14, 5'h01, 3'd2, 5'd0, OPC_JAL));
        run_request(encode(7'h7f, 5'h18, 5'd2, 3'd0, 5'd1, OPC_JALR));
        check_equal("uops.imm", uops.imm, 32'hffff_fff8);  // jalr x1, -8(x2)
        run_request(encode(7'h7f, 5'd3, 5'd4, 3'd0, 5'h1d, OPC_BRANCH));
        run_request(encode(7'h05, 5'd9, 5'd10, 3'd7, 5'h0b, OPC_BRANCH));
        run_request(encode(7'h7c, 5'd7, 5'd8, 3'd2, 5'h11, OPC_STORE));
        run_request(encode(7'h3a, 5'h15, 5'd11, 3'd0, 5'd12, OPC_OP_IMM));
    endtask

    task automatic test_alu_and_memory();
        run_request(encode(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OPC_OP));
        run_request(encode(7'h20, 5'd3, 5'd2, 3'd0, 5'd1, OPC_OP));  // sub
        check_equal("uops.ex_alu.alt", uops.ex_alu.alt, 1'b1);
        run_request(encode(7'h20, 5'd4, 5'd5, 3'd5, 5'd6, OPC_OP));
        run_request(encode(7'h00, 5'd4, 5'd5, 3'd5, 5'd6, OPC_OP));
        run_request(encode(7'h00, 5'd7, 5'd8, 3'd2, 5'd9, OPC_OP));
        run_request(encode(7'h20, 5'd3, 5'd1, 3'd5, 5'd2, OPC_OP_IMM));
        run_request(encode(7'h00, 5'd3, 5'd1, 3'd5, 5'd2, OPC_OP_IMM));
        run_request(encode(7'h00, 5'd31, 5'd1, 3'd1, 5'd2, OPC_OP_IMM));
        run_request(encode(7'h20, 5'd0, 5'd1, 3'd4, 5'd2, OPC_OP_IMM));  // xori, no alt
        check_equal("uops.ex_alu.alt", uops.ex_alu.alt, 1'b0);
        run_request(encode(7'h00, 5'h04, 5'd5, 3'd0, 5'd6, OPC_LOAD));
        run_request(encode(7'h7f, 5'h10, 5'd5, 3'd2, 5'd6, OPC_LOAD));
        run_request(encode(7'h00, 5'h08, 5'd15, 3'd5, 5'd14, OPC_LOAD));
        run_request(encode(7'h00, 5'd9, 5'd5, 3'd0, 5'd3, OPC_STORE));
        run_request(encode(7'h01, 5'd9, 5'd5, 3'd1, 5'd3, OPC_STORE));
        run_request(encode(7'h7f, 5'd13, 5'd12, 3'd2, 5'h1c, OPC_STORE));
        check_equal("uops.ma_mem.is_store", uops.ma_mem.is_store, 1'b1);
        run_request(encode(7'h07, 5'h1f, 5'd0, 3'd0, 5'd0, OPC_MISC_MEM));  // fence iorw, iorw
        run_request(32'h0000_100f);  // fence.i
    endtask

    task automatic illegal_request(input logic [31:0] word);
        run_request(word);
        check_equal("fault", fault, 1'b1);
        check_no_enables();
    endtask

    task automatic test_illegal();
        illegal_request(encode(7'h00, 5'd3, 5'd16, 3'd0, 5'd1, OPC_OP));
        illegal_request(encode(7'h01, 5'd0, 5'd0, 3'd0, 5'd20, OPC_LUI));
        illegal_request(encode(7'h00, 5'd17, 5'd1, 3'd2, 5'd0, OPC_STORE));
        illegal_request(encode(7'h00, 5'd0, 5'd1, 3'd3, 5'd2, OPC_LOAD));
        illegal_request(encode(7'h00, 5'd0, 5'd1, 3'd1, 5'd2, OPC_JALR));
        illegal_request(encode(7'h00, 5'd2, 5'd1, 3'd2, 5'd0, OPC_BRANCH));
        illegal_request(encode(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP));  // mul
        illegal_request(encode(7'h20, 5'd2, 5'd1, 3'd1, 5'd3, OPC_OP));
        illegal_request(encode(7'h20, 5'd2, 5'd1, 3'd1, 5'd3, OPC_OP_IMM));
        illegal_request(32'h0000_0073);  // ecall
        illegal_request(encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'b0110001));
        illegal_request(encode(7'h00, 5'd0, 5'd0, 3'd1, 5'd5, OPC_MISC_MEM));
        illegal_request(encode(7'h00, 5'd1, 5'd0, 3'd1, 5'd0, OPC_MISC_MEM));
    endtask

    task automatic test_sticky_fault();
        illegal_request(32'h0000_0073);
        repeat (6) begin
            @(negedge clk);
            check_equal("fault", fault, 1'b1);
            check_equal("busy", busy, 1'b0);
        end
        run_request(encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP));
        check_equal("fault", fault, 1'b0);
    endtask

    task automatic test_random_sweep();
        logic [31:0] state;
        logic [31:0] word;
        state = SEED;
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            state = xorshift(state);
            word = state;
            if (i % 2 == 1) begin
                word[6:0] = KEPT_OPCODES[word[31:28] % 10];  // Mostly decodable
            end
            if (i % 4 == 1) begin
                word[11] = 1'b0;
                word[19] = 1'b0;
                word[24] = 1'b0;
            end
            run_request(word);
        end
    endtask

    initial begin
        available = 1'b0;
        instr = 32'h0000_0013;
        errors = 0;
        checks = 0;
        @(posedge rst_n);
        @(negedge clk);
        test_reset_and_handshake();
        test_immediates();
        test_alu_and_memory();
        test_illegal();
        test_sticky_fault();
        test_random_sweep();
        @(negedge clk);
        errors += u_dut.u_properties.failures;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)",
                 checks, errors, u_dut.u_properties.failures);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/rv_isa_pkg.sv
source/decode_pkg.sv
source/opcode_classifier.sv
source/field_checker.sv
source/imm_gen.sv
source/microcode_gen.sv
source/decode_control.sv
source/instruction_decoder.sv
test/tb_clock.sv
test/decoder_properties.sv
test/instruction_decoder_tb.sv

/* Bender.yml */
package:
  name: instruction_decoder

sources:
  - files:
      - source/rv_isa_pkg.sv
      - source/decode_pkg.sv
      - source/opcode_classifier.sv
      - source/field_checker.sv
      - source/imm_gen.sv
      - source/microcode_gen.sv
      - source/decode_control.sv
      - source/instruction_decoder.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/decoder_properties.sv
      - test/instruction_decoder_tb.sv
